//--- Makefile
TOP = tb_dataframe_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
dataframe_pkg.sv
sync_fifo.sv
channel_capture.sv
frame_arbiter.sv
dataframe_gen.sv
dataframe_top.sv
tb_dataframe_top.sv

//--- channel_capture.sv
`timescale 1ns/1ps

module channel_capture import dataframe_pkg::*; (
    input  logic       ACLK,
    input  logic       ARESET,
    input  adc_in_t    adc,
    input  frame_len_t frame_len,
    input  logic       fifo_full,
    output logic       fifo_wr_en,
    output beat_t      fifo_wr_data,
    output logic       req,
    input  logic       ack,
    output hf_desc_t   desc,
    output logic       overflow
);

    logic        have_low;   // low half of a pair is waiting
    sample_t     low_q;
    frame_len_t  beat_cnt;
    frame_len_t  len_q;      // length of the frame in progress
    logic [15:0] csum;
    seq_t        seq;
    logic        first_smp;
    logic        pair_done;
    logic        frame_done;

    assign first_smp  = adc.valid && !have_low && (beat_cnt == '0);
    assign pair_done  = adc.valid && have_low;
    assign frame_done = pair_done && (beat_cnt == len_q - 8'd1);

    assign fifo_wr_en   = pair_done && !fifo_full;
    assign fifo_wr_data = {adc.data, low_q};

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            have_low <= 1'b0;
            beat_cnt <= '0;
            len_q    <= frame_len_t'(MIN_FRAME_BEATS);
            csum     <= '0;
            seq      <= '0;
            req      <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (adc.valid) begin
                have_low <= !have_low;
                csum     <= frame_done ? '0 : (csum ^ adc.data);
            end
            if (first_smp) begin
                len_q <= frame_len;
            end
            if (pair_done) begin
                beat_cnt <= frame_done ? '0 : beat_cnt + 8'd1;
                if (fifo_full) begin
                    overflow <= 1'b1; // beat dropped
                end
            end
            if (req && ack) begin
                req <= 1'b0;
            end
            if (frame_done) begin
                seq <= seq + 16'd1;
                if (req || ack) begin
                    overflow <= 1'b1; // descriptor lost while the handshake is busy
                end else begin
                    req <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (adc.valid && !have_low) begin
            low_q <= adc.data;
        end
        if (frame_done && !req && !ack) begin
            desc.ch_id     <= '0;        // stamped by the arbiter
            desc.frame_len <= len_q;
            desc.seq       <= seq;
            desc.checksum  <= csum ^ adc.data;
        end
    end

    a_desc_stable: assert property (@(posedge ACLK) disable iff (ARESET)
        req |=> $stable(desc));

    a_len_range: assert property (@(posedge ACLK) disable iff (ARESET)
        first_smp |-> (frame_len >= MIN_FRAME_BEATS) && (frame_len <= MAX_FRAME_BEATS));

endmodule

//--- dataframe_gen.sv
`timescale 1ns/1ps

module dataframe_gen import dataframe_pkg::*; (
    input  logic              ACLK,
    input  logic              ARESET,
    input  logic              hf_empty,
    input  hf_desc_t          hf_dout,
    output logic              hf_rd_en,
    input  logic [NUM_CH-1:0] smp_empty,
    input  beat_t             smp_dout [NUM_CH],
    output logic [NUM_CH-1:0] smp_rd_en,
    output axis_beat_t        m_axis,
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output logic              frame_error
);

    hf_desc_t   desc_q;     // descriptor of the frame being sent
    logic       busy;
    frame_len_t pos;        // index of the next beat to build
    logic       load;
    logic       is_hdr0;
    logic       is_hdr1;
    logic       is_footer;
    logic       is_payload;
    logic       smp_avail;
    logic       fault;
    logic       advance;
    axis_beat_t next_beat;

    // output slot is free or being taken this cycle
    assign load = !m_axis_tvalid || m_axis_tready;

    assign is_hdr0    = (pos == 8'd0);
    assign is_hdr1    = (pos == 8'd1);
    assign is_footer  = (pos == desc_q.frame_len + 8'd2);
    assign is_payload = !is_hdr0 && !is_hdr1 && !is_footer;
    assign smp_avail  = !smp_empty[desc_q.ch_id];

    // payload beats are all written before the descriptor, so empty here is a fault
    assign fault   = busy && load && is_payload && !smp_avail && !frame_error;
    assign advance = busy && load && !frame_error && (!is_payload || smp_avail);

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            smp_rd_en[i] = advance && is_payload && (desc_q.ch_id == ch_id_t'(i));
        end
    end

    // fetch while idle, or at the footer so frames run back to back
    assign hf_rd_en = !frame_error && !hf_empty && (!busy || (advance && is_footer));

    always_comb begin
        next_beat.tkeep = '1;
        next_beat.tlast = 1'b0;
        if (is_hdr0) begin
            next_beat.tdata = hdr0_word(desc_q);
        end else if (is_hdr1) begin
            next_beat.tdata = hdr1_word(desc_q);
        end else if (is_footer) begin
            next_beat.tdata = footer_word(desc_q);
            next_beat.tkeep = FOOTER_KEEP;
            next_beat.tlast = 1'b1;
        end else begin
            next_beat.tdata = smp_dout[desc_q.ch_id];
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            busy          <= 1'b0;
            pos           <= '0;
            m_axis_tvalid <= 1'b0;
            frame_error   <= 1'b0;
        end else begin
            if (fault) begin
                frame_error   <= 1'b1; // sticky, generator stops here
                m_axis_tvalid <= 1'b0;
            end else if (advance) begin
                m_axis_tvalid <= 1'b1;
                pos           <= is_footer ? '0 : pos + 8'd1;
                if (is_footer && hf_empty) begin
                    busy <= 1'b0;
                end
            end else if (load) begin
                m_axis_tvalid <= 1'b0;
            end
            if (hf_rd_en) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (hf_rd_en) begin
            desc_q <= hf_dout;
        end
        if (advance) begin
            m_axis <= next_beat;
        end
    end

    a_axis_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis));

endmodule

//--- dataframe_pkg.sv
package dataframe_pkg;

    localparam int NUM_CH            = 2;
    localparam logic [15:0] SYNC_WORD = 16'hA5C3;
    localparam int SAMPLE_FIFO_DEPTH = 32;
    localparam int HF_FIFO_DEPTH     = 4;
    localparam int MIN_FRAME_BEATS   = 2;
    localparam int MAX_FRAME_BEATS   = 15;
    localparam logic [3:0] FOOTER_KEEP = 4'b0011; // low half of the footer only

    typedef logic [15:0] sample_t;
    typedef logic [31:0] beat_t;      // first sample in [15:0]
    typedef logic        ch_id_t;
    typedef logic [7:0]  frame_len_t; // payload beats
    typedef logic [15:0] seq_t;

    typedef struct packed {
        logic    valid;
        sample_t data;
    } adc_in_t;

    typedef struct packed {
        ch_id_t      ch_id;
        frame_len_t  frame_len;
        seq_t        seq;
        logic [15:0] checksum;
    } hf_desc_t;

    typedef struct packed {
        beat_t      tdata;
        logic [3:0] tkeep;
        logic       tlast;
    } axis_beat_t;

    // sync | ch_id | frame_len
    function automatic beat_t hdr0_word(hf_desc_t d);
        return {SYNC_WORD, 8'(d.ch_id), d.frame_len};
    endfunction

    function automatic beat_t hdr1_word(hf_desc_t d);
        return {16'h0000, d.seq};
    endfunction

    // upper half padded with ones, only the checksum half is kept
    function automatic beat_t footer_word(hf_desc_t d);
        return {16'hFFFF, d.checksum};
    endfunction

endpackage

//--- dataframe_top.sv
`timescale 1ns/1ps

module dataframe_top import dataframe_pkg::*; (
    input  logic              ACLK,
    input  logic              ARESET,
    input  adc_in_t           adc [NUM_CH],
    input  frame_len_t        frame_len,
    output axis_beat_t        m_axis,
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output logic [NUM_CH-1:0] overflow,
    output logic              frame_error
);

    logic [NUM_CH-1:0] smp_full;
    logic [NUM_CH-1:0] smp_wr_en;
    beat_t             smp_wr_data [NUM_CH];
    logic [NUM_CH-1:0] smp_empty;
    beat_t             smp_dout [NUM_CH];
    logic [NUM_CH-1:0] smp_rd_en;

    logic [NUM_CH-1:0] req;
    logic [NUM_CH-1:0] ack;
    hf_desc_t          desc [NUM_CH];

    logic     hf_full;
    logic     hf_wr_en;
    hf_desc_t hf_wr_data;
    logic     hf_empty;
    hf_desc_t hf_dout;
    logic     hf_rd_en;

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        channel_capture u_capture (
            .ACLK         (ACLK),
            .ARESET       (ARESET),
            .adc          (adc[i]),
            .frame_len    (frame_len),
            .fifo_full    (smp_full[i]),
            .fifo_wr_en   (smp_wr_en[i]),
            .fifo_wr_data (smp_wr_data[i]),
            .req          (req[i]),
            .ack          (ack[i]),
            .desc         (desc[i]),
            .overflow     (overflow[i])
        );

        sync_fifo #(.payload_t(beat_t), .DEPTH(SAMPLE_FIFO_DEPTH)) u_smp_fifo (
            .ACLK    (ACLK),
            .ARESET  (ARESET),
            .wr_en   (smp_wr_en[i]),
            .wr_data (smp_wr_data[i]),
            .full    (smp_full[i]),
            .rd_en   (smp_rd_en[i]),
            .dout    (smp_dout[i]),
            .empty   (smp_empty[i])
        );
    end

    frame_arbiter u_arbiter (
        .ACLK       (ACLK),
        .ARESET     (ARESET),
        .req        (req),
        .desc       (desc),
        .ack        (ack),
        .hf_full    (hf_full),
        .hf_wr_en   (hf_wr_en),
        .hf_wr_data (hf_wr_data)
    );

    sync_fifo #(.payload_t(hf_desc_t), .DEPTH(HF_FIFO_DEPTH)) u_hf_fifo (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr_en   (hf_wr_en),
        .wr_data (hf_wr_data),
        .full    (hf_full),
        .rd_en   (hf_rd_en),
        .dout    (hf_dout),
        .empty   (hf_empty)
    );

    dataframe_gen u_gen (
        .ACLK          (ACLK),
        .ARESET        (ARESET),
        .hf_empty      (hf_empty),
        .hf_dout       (hf_dout),
        .hf_rd_en      (hf_rd_en),
        .smp_empty     (smp_empty),
        .smp_dout      (smp_dout),
        .smp_rd_en     (smp_rd_en),
        .m_axis        (m_axis),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .frame_error   (frame_error)
    );

endmodule

//--- frame_arbiter.sv
`timescale 1ns/1ps

module frame_arbiter import dataframe_pkg::*; (
    input  logic              ACLK,
    input  logic              ARESET,
    input  logic [NUM_CH-1:0] req,
    input  hf_desc_t          desc [NUM_CH],
    output logic [NUM_CH-1:0] ack,
    input  logic              hf_full,
    output logic              hf_wr_en,
    output hf_desc_t          hf_wr_data
);

    logic   grant_vld;
    logic   written;    // descriptor of the granted channel is in the FIFO
    ch_id_t grant_idx;
    ch_id_t rr_ptr;     // channel with the highest priority
    ch_id_t pick_idx;
    logic   pick_vld;

    // scan from the far end so the channel nearest rr_ptr wins
    always_comb begin
        ch_id_t idx;
        pick_vld = 1'b0;
        pick_idx = rr_ptr;
        for (int k = NUM_CH - 1; k >= 0; k--) begin
            idx = ch_id_t'((int'(rr_ptr) + k) % NUM_CH);
            if (req[idx] && !ack[idx]) begin
                pick_vld = 1'b1;
                pick_idx = idx;
            end
        end
    end

    assign hf_wr_en = grant_vld && !written && !hf_full;

    always_comb begin
        hf_wr_data       = desc[grant_idx];
        hf_wr_data.ch_id = grant_idx;
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            grant_vld <= 1'b0;
            written   <= 1'b0;
            grant_idx <= '0;
            rr_ptr    <= '0;
            ack       <= '0;
        end else if (!grant_vld) begin
            if (pick_vld) begin
                grant_vld <= 1'b1;
                grant_idx <= pick_idx;
                written   <= 1'b0;
            end
        end else if (!written) begin
            if (!hf_full) begin
                written        <= 1'b1;
                ack[grant_idx] <= 1'b1;
            end
        end else if (!req[grant_idx]) begin
            ack[grant_idx] <= 1'b0;
            grant_vld      <= 1'b0;
            rr_ptr         <= ch_id_t'((int'(grant_idx) + 1) % NUM_CH);
        end
    end

    a_ack_onehot: assert property (@(posedge ACLK) disable iff (ARESET)
        $onehot0(ack));

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     ACLK,
    input  logic     ARESET,
    input  logic     wr_en,
    input  payload_t wr_data,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    payload_t mem [DEPTH];

    // one extra bit tells full from empty
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                   (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);

    assign dout = mem[rd_ptr[$clog2(DEPTH)-1:0]]; // first word falls through

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (wr_en && !full) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= wr_data;
        end
    end

    // writers and readers must check the flags themselves
    a_no_write_full: assert property (@(posedge ACLK) disable iff (ARESET)
        wr_en |-> !full);

    a_no_read_empty: assert property (@(posedge ACLK) disable iff (ARESET)
        rd_en |-> !empty);

endmodule

//--- tb_dataframe_top.sv
`timescale 1ns/1ps

module tb_dataframe_top import dataframe_pkg::*; ();

    typedef axis_beat_t frame_t [$];
    typedef enum int {RDY_LOW, RDY_HIGH, RDY_RANDOM} ready_mode_t;

    logic              ACLK = 1'b0;
    logic              ARESET;
    adc_in_t           adc [NUM_CH];
    frame_len_t        frame_len;
    axis_beat_t        m_axis;
    logic              m_axis_tvalid;
    logic              m_axis_tready;
    logic [NUM_CH-1:0] overflow;
    logic              frame_error;

    logic [31:0] lfsr;
    sample_t     exp_smp_q [NUM_CH][$]; // samples sent with the oldest first
    frame_len_t  exp_len_q [NUM_CH][$]; // one entry per frame started
    seq_t        exp_seq [NUM_CH];
    axis_beat_t  got_q [$];
    int          frames_seen;
    int          err_cnt;
    int          err_at_start;
    int          bad_tests;
    bit          timed_out;
    string       cur_test;

    dataframe_top u_dataframe_top (
        .ACLK          (ACLK),
        .ARESET        (ARESET),
        .adc           (adc),
        .frame_len     (frame_len),
        .m_axis        (m_axis),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .overflow      (overflow),
        .frame_error   (frame_error)
    );

    always #2 ACLK = ~ACLK;

    // taps 32 22 2 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic frame_t ref_frame(ch_id_t ch, frame_len_t len, seq_t seq,
                                         sample_t smp [$]);
        frame_t      f;
        axis_beat_t  b;
        logic [15:0] csum;
        csum = '0;
        foreach (smp[i]) begin
            csum = csum ^ smp[i];
        end
        b.tkeep = 4'hF;
        b.tlast = 1'b0;
        b.tdata = {SYNC_WORD, 7'b0, ch, len};
        f.push_back(b);
        b.tdata = {16'h0000, seq};
        f.push_back(b);
        for (int i = 0; i < int'(len); i++) begin
            b.tdata = {smp[2*i+1], smp[2*i]}; // earlier sample in the low half
            f.push_back(b);
        end
        b.tdata = {16'hFFFF, csum};
        b.tkeep = FOOTER_KEEP;
        b.tlast = 1'b1;
        f.push_back(b);
        return f;
    endfunction

    task automatic check_beat(string name, axis_beat_t exp, axis_beat_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h/%h/%b actual %h/%h/%b", name,
                     exp.tdata, exp.tkeep, exp.tlast, act.tdata, act.tkeep, act.tlast);
            err_cnt++;
        end
    endtask

    task automatic check_flags(string name, logic [NUM_CH-1:0] exp_ovf, logic exp_err,
                               logic [NUM_CH-1:0] act_ovf, logic act_err);
        if (exp_ovf !== act_ovf || exp_err !== act_err) begin
            $display("CHECK FAILED %s overflow/frame_error expected %b/%b actual %b/%b",
                     name, exp_ovf, exp_err, act_ovf, act_err);
            err_cnt++;
        end
    endtask

    task automatic check_frame();
        ch_id_t     ch;
        frame_len_t len;
        sample_t    smp [$];
        frame_t     exp;
        int         n;
        ch = got_q[0].tdata[8];
        if (exp_len_q[ch].size() == 0) begin
            $display("%s: frame from channel %0d that was never sent", cur_test, ch);
            err_cnt++;
            return;
        end
        len = exp_len_q[ch].pop_front();
        for (int i = 0; i < 2 * int'(len); i++) begin
            smp.push_back(exp_smp_q[ch].pop_front());
        end
        exp = ref_frame(ch, len, exp_seq[ch], smp);
        exp_seq[ch]++;
        if (exp.size() != got_q.size()) begin
            $display("CHECK FAILED %s ch%0d beat count expected %0d actual %0d", cur_test,
                     ch, exp.size(), got_q.size());
            err_cnt++;
        end
        n = (exp.size() < got_q.size()) ? exp.size() : got_q.size();
        for (int i = 0; i < n; i++) begin
            check_beat($sformatf("%s ch%0d beat%0d", cur_test, ch, i), exp[i], got_q[i]);
        end
        frames_seen++;
    endtask

    always @(posedge ACLK) begin
        if (!ARESET && m_axis_tvalid && m_axis_tready) begin
            got_q.push_back(m_axis);
            if (m_axis.tlast) begin
                check_frame();
                got_q.delete();
            end
        end
    end

    // sends whole frames on the masked channels and waits for them when drain is set
    task automatic stream(logic [NUM_CH-1:0] mask, int frames, frame_len_t len,
                          int gap_bits, ready_mode_t mode, bit drain);
        int      left [NUM_CH];
        int      total_left;
        int      target;
        int      cyc;
        sample_t s;
        if (timed_out) begin
            return;
        end
        target     = frames_seen;
        total_left = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            left[c]    = mask[c] ? frames * 2 * int'(len) : 0;
            total_left += left[c];
            target     += mask[c] ? frames : 0;
        end
        cyc = 0;
        while (total_left > 0 || (drain && frames_seen < target)) begin
            if (cyc == 20000) begin
                $display("%s: timeout, %0d frames still missing", cur_test,
                         target - frames_seen);
                err_cnt++;
                timed_out = 1'b1;
                break;
            end
            @(posedge ACLK);
            frame_len <= frame_len_t'(17) - len; // mid frame value that the DUT ignores
            for (int c = 0; c < NUM_CH; c++) begin
                adc[c] <= '0;
                if (left[c] > 0 && cyc % 4 == 2 * c && take_bits(gap_bits) == 0) begin
                    s = sample_t'(take_bits(16));
                    adc[c] <= '{valid: 1'b1, data: s};
                    if (left[c] % (2 * int'(len)) == 0) begin
                        exp_len_q[c].push_back(len);
                        frame_len <= len;
                    end
                    exp_smp_q[c].push_back(s);
                    left[c]--;
                    total_left--;
                end
            end
            case (mode)
                RDY_LOW:  m_axis_tready <= 1'b0;
                RDY_HIGH: m_axis_tready <= 1'b1;
                default:  m_axis_tready <= (take_bits(2) != 0);
            endcase
            cyc++;
        end
        @(posedge ACLK);
        for (int c = 0; c < NUM_CH; c++) begin
            adc[c] <= '0;
        end
    endtask

    task automatic check_drained();
        for (int c = 0; c < NUM_CH; c++) begin
            if (exp_len_q[c].size() != 0 || exp_smp_q[c].size() != 0) begin
                $display("%s: channel %0d has frames that never came out", cur_test, c);
                err_cnt++;
            end
        end
    endtask

    task automatic begin_test(string name);
        cur_test     = name;
        err_at_start = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == err_at_start) begin
            $display("[%s] ok", cur_test);
        end else begin
            bad_tests++;
            $display("[%s] %0d errors", cur_test, err_cnt - err_at_start);
        end
    endtask

    initial begin
        lfsr          = 32'hcbd6_a21d;
        ARESET        = 1'b1;
        frame_len     = 8'd4;
        m_axis_tready = 1'b0;
        frames_seen   = 0;
        err_cnt       = 0;
        bad_tests     = 0;
        timed_out     = 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            adc[c]     = '0;
            exp_seq[c] = '0;
        end
        repeat (8) @(posedge ACLK);
        ARESET <= 1'b0;

        begin_test("idle_after_reset");
        repeat (50) begin
            @(posedge ACLK);
            if (m_axis_tvalid) begin
                $display("%s: m_axis_tvalid went high with no input", cur_test);
                err_cnt++;
            end
        end
        check_flags(cur_test, '0, 1'b0, overflow, frame_error);
        end_test();

        begin_test("single_frame");
        stream(2'b01, 1, 8'd4, 0, RDY_HIGH, 1'b1);
        check_flags(cur_test, '0, 1'b0, overflow, frame_error);
        check_drained();
        end_test();

        begin_test("two_channels");
        stream(2'b11, 3, 8'd5, 0, RDY_HIGH, 1'b1);
        check_flags(cur_test, '0, 1'b0, overflow, frame_error);
        check_drained();
        end_test();

        begin_test("backpressure");
        stream(2'b11, 4, 8'd6, 1, RDY_RANDOM, 1'b1);
        check_flags(cur_test, '0, 1'b0, overflow, frame_error);
        check_drained();
        end_test();

        begin_test("len_change");
        stream(2'b10, 1, 8'd2, 1, RDY_RANDOM, 1'b1);
        stream(2'b10, 1, 8'd15, 1, RDY_RANDOM, 1'b1);
        stream(2'b10, 1, 8'd7, 1, RDY_RANDOM, 1'b1);
        check_flags(cur_test, '0, 1'b0, overflow, frame_error);
        check_drained();
        end_test();

        begin_test("overflow");
        stream(2'b01, 12, 8'd4, 0, RDY_LOW, 1'b0); // 48 beats into a 32 deep FIFO
        @(posedge ACLK);
        check_flags(cur_test, 2'b01, 1'b0, overflow, frame_error);
        end_test();

        $display("tests: 6, failed tests: %0d, failed checks: %0d", bad_tests, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
